// ==== compile.f ====
ingest_pkg.sv
axi_rd_if.sv
line_stream_if.sv
burst_reader.sv
line_fifo.sv
read_channel.sv
ingest_ctrl.sv
input_channel.sv
tb_mem_model.sv
tb_input_channel.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_input_channel
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status follows the search for the pass line in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_input_channel.sv ====
`timescale 1ns/1ps

module tb_input_channel;
  import ingest_pkg::*;

  localparam int NUM_RUNS     = 20;
  localparam int MAX_LINES    = 40;
  localparam int STALL_FACTOR = 6;
  localparam int HOLD_CYCLES  = 80;
  localparam int CYCLE_LIMIT  = NUM_RUNS * (2 * MAX_LINES + 40 * STALL_FACTOR);

  logic              data_clk;
  logic              data_rst_n;
  logic              ctrl_start;
  logic              ctrl_done;
  logic [HASH_W-1:0] nfa_hash;
  logic [ADDR_W-1:0] nfadata_ptr;
  logic [LEN_W-1:0]  nfadata_cls;
  logic [ADDR_W-1:0] queries_ptr;
  logic [LEN_W-1:0]  queries_cls;
  logic              m_axi_arvalid;
  logic              m_axi_arready;
  logic [ADDR_W-1:0] m_axi_araddr;
  logic [LEN8_W-1:0] m_axi_arlen;
  logic              m_axi_rvalid;
  logic              m_axi_rready;
  logic [DATA_W-1:0] m_axi_rdata;
  logic              m_axi_rlast;
  logic              m_axis_tvalid;
  logic              m_axis_tready;
  logic [DATA_W-1:0] m_axis_tdata;
  logic              m_axis_tlast;
  line_type_e        m_axis_ttype;
  logic              ar_stall;
  logic              r_stall;

  logic [31:0]       lfsr;
  logic [HASH_W-1:0] run_hash [NUM_RUNS];
  logic [ADDR_W-1:0] run_nptr [NUM_RUNS];
  logic [ADDR_W-1:0] run_qptr [NUM_RUNS];
  int                run_ncls [NUM_RUNS];
  int                run_qcls [NUM_RUNS];
  logic [HASH_W-1:0] model_hash;
  // Expected line packed as {ttype, tlast, tdata}
  logic [65:0]       exp_q [$];
  logic [ADDR_W-1:0] phase_addr [2];
  int                phase_left [2];
  int                phase_cnt;
  int                phase_idx;
  int                inflight;
  int                lines_seen;
  int                errors;
  int                cycles;
  int                hold_left;
  logic              run_done;

  input_channel UUT (
    .data_clk(data_clk), .data_rst_n(data_rst_n),
    .ctrl_start(ctrl_start), .ctrl_done(ctrl_done), .nfa_hash(nfa_hash),
    .nfadata_ptr(nfadata_ptr), .nfadata_cls(nfadata_cls),
    .queries_ptr(queries_ptr), .queries_cls(queries_cls),
    .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
    .m_axi_araddr(m_axi_araddr), .m_axi_arlen(m_axi_arlen),
    .m_axi_rvalid(m_axi_rvalid), .m_axi_rready(m_axi_rready),
    .m_axi_rdata(m_axi_rdata), .m_axi_rlast(m_axi_rlast),
    .m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
    .m_axis_tdata(m_axis_tdata), .m_axis_tlast(m_axis_tlast),
    .m_axis_ttype(m_axis_ttype)
  );

  tb_mem_model mem_model (
    .data_clk(data_clk), .data_rst_n(data_rst_n),
    .ar_stall(ar_stall), .r_stall(r_stall),
    .arvalid(m_axi_arvalid), .arready(m_axi_arready),
    .araddr(m_axi_araddr), .arlen(m_axi_arlen),
    .rvalid(m_axi_rvalid), .rready(m_axi_rready),
    .rdata(m_axi_rdata), .rlast(m_axi_rlast)
  );

  always #50 data_clk = ~data_clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random source and expected stream
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic expect_lines(input logic [ADDR_W-1:0] base, input int count,
                              input line_type_e kind);
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < count; i++) begin
      a = base + ADDR_W'(i * LINE_BYTES);
      exp_q.push_back({kind, i == count - 1, a[31:0], ~a[31:0]});
    end
  endtask

  task automatic check_request();
    int beats;
    beats = int'(m_axi_arlen) + 1;
    if (phase_left[phase_idx] == 0 && phase_idx < phase_cnt - 1) begin
      phase_idx++;
    end
    assert (beats <= LINE_BURST) else begin
      $display("CHECK FAILED m_axi_arlen: got %h, limit %h", m_axi_arlen, LINE_BURST - 1);
      errors++;
    end
    assert (m_axi_araddr == phase_addr[phase_idx]) else begin
      $display("CHECK FAILED m_axi_araddr: got %h expected %h",
               m_axi_araddr, phase_addr[phase_idx]);
      errors++;
    end
    assert (beats <= phase_left[phase_idx]) else begin
      $display("Burst of %0d lines runs past the end of its phase", beats);
      errors++;
    end
    phase_addr[phase_idx] += ADDR_W'(beats * LINE_BYTES);
    phase_left[phase_idx] -= beats;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor on the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge data_clk) begin
    logic [65:0] head;
    logic        exp_done;
    exp_done = 1'b0;
    if (data_rst_n) begin
      if (m_axi_arvalid && m_axi_arready) begin
        check_request();
      end
      // Room is reserved before the request, so a burst never waits on rready
      assert (!m_axi_rvalid || m_axi_rready) else begin
        $display("CHECK FAILED m_axi_rready: got %h expected %h", m_axi_rready, 1'b1);
        errors++;
      end
      if (m_axi_rvalid && m_axi_rready) begin
        inflight++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        assert (exp_q.size() != 0) else begin
          $display("Line %h delivered while no line was expected", m_axis_tdata);
          errors++;
        end
        if (exp_q.size() != 0) begin
          head = exp_q.pop_front();
          exp_done = head[65] && head[64];
          assert (m_axis_tdata == head[63:0]) else begin
            $display("CHECK FAILED m_axis_tdata: got %h expected %h", m_axis_tdata, head[63:0]);
            errors++;
          end
          assert (m_axis_tlast == head[64]) else begin
            $display("CHECK FAILED m_axis_tlast: got %h expected %h", m_axis_tlast, head[64]);
            errors++;
          end
          assert (m_axis_ttype == line_type_e'(head[65])) else begin
            $display("CHECK FAILED m_axis_ttype: got %h expected %h", m_axis_ttype, head[65]);
            errors++;
          end
        end
        inflight--;
        lines_seen++;
      end
      assert (inflight <= FIFO_DEPTH) else begin
        $display("%0d lines in flight, more than the line buffer holds", inflight);
        errors++;
      end
      assert (ctrl_done == exp_done) else begin
        $display("CHECK FAILED ctrl_done: got %h expected %h", ctrl_done, exp_done);
        errors++;
      end
      if (ctrl_done) begin
        run_done = 1'b1;
      end
    end
  end

  // Long output stall at the start of about half the runs fills the line buffer
  always @(posedge data_clk) begin
    if (ctrl_start) begin
      hold_left = (rand_bits(1) != 0) ? HOLD_CYCLES : 0;
    end else if (hold_left > 0) begin
      hold_left--;
    end
  end

  // Ready and stall choices for every cycle
  always @(negedge data_clk) begin
    m_axis_tready = (rand_bits(2) != 0) && (hold_left == 0);
    ar_stall      = (rand_bits(2) == 0);
    r_stall       = (rand_bits(2) == 0);
  end

  always @(posedge data_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a run never finished", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [HASH_W-1:0] prev_hash;
    logic              reload;
    int                err_start;
    data_clk      = 1'b0;
    data_rst_n    = 1'b0;
    ctrl_start    = 1'b0;
    nfa_hash      = '0;
    nfadata_ptr   = '0;
    nfadata_cls   = '0;
    queries_ptr   = '0;
    queries_cls   = '0;
    m_axis_tready = 1'b0;
    ar_stall      = 1'b1;
    r_stall       = 1'b1;
    lfsr          = 32'hc189dda2;
    model_hash    = '0;
    inflight      = 0;
    lines_seen    = 0;
    errors        = 0;
    cycles        = 0;
    hold_left     = 0;
    run_done      = 1'b0;
    phase_cnt     = 1;
    phase_idx     = 0;
    prev_hash     = '0;

    // First run keeps the zero hash from reset and later ones repeat about a third
    for (int r = 0; r < NUM_RUNS; r++) begin
      if (r == 0 || rand_bits(8) < 85) begin
        run_hash[r] = prev_hash;
      end else begin
        run_hash[r] = {rand_bits(32), rand_bits(32)};
      end
      prev_hash   = run_hash[r];
      run_nptr[r] = 64'h1000_0000 + ADDR_W'(rand_bits(16)) * ADDR_W'(LINE_BYTES);
      run_qptr[r] = 64'h2000_0000 + ADDR_W'(rand_bits(16)) * ADDR_W'(LINE_BYTES);
      run_ncls[r] = int'(rand_bits(6) % MAX_LINES) + 1;
      run_qcls[r] = int'(rand_bits(6) % MAX_LINES) + 1;
    end

    repeat (3) @(negedge data_clk);
    data_rst_n = 1'b1;

    for (int r = 0; r < NUM_RUNS; r++) begin
      reload     = (run_hash[r] != model_hash);
      model_hash = run_hash[r];
      err_start  = errors;
      phase_idx  = 0;
      phase_cnt  = reload ? 2 : 1;
      phase_addr[0] = reload ? run_nptr[r] : run_qptr[r];
      phase_left[0] = reload ? run_ncls[r] : run_qcls[r];
      phase_addr[1] = run_qptr[r];
      phase_left[1] = reload ? run_qcls[r] : 0;
      if (reload) begin
        expect_lines(run_nptr[r], run_ncls[r], NFA_LINE);
      end
      expect_lines(run_qptr[r], run_qcls[r], QUERY_LINE);

      nfa_hash    = run_hash[r];
      nfadata_ptr = run_nptr[r];
      nfadata_cls = LEN_W'(run_ncls[r]);
      queries_ptr = run_qptr[r];
      queries_cls = LEN_W'(run_qcls[r]);
      run_done    = 1'b0;
      ctrl_start  = 1'b1;
      @(negedge data_clk);
      ctrl_start = 1'b0;
      while (!run_done) begin
        @(negedge data_clk);
      end

      assert (exp_q.size() == 0) else begin
        $display("%0d expected lines never arrived", exp_q.size());
        errors++;
      end
      assert (phase_left[0] == 0 && phase_left[1] == 0) else begin
        $display("Requested burst lengths do not add up to the line counts");
        errors++;
      end
      $display("run %0d: automaton %s, %0d + %0d lines, %0d errors", r,
               reload ? "reloaded" : "skipped", reload ? run_ncls[r] : 0,
               run_qcls[r], errors - err_start);
    end

    $display("runs %0d, lines %0d, errors %0d", NUM_RUNS, lines_seen, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
  input  logic                          data_clk,
  input  logic                          data_rst_n,
  input  logic                          ar_stall,
  input  logic                          r_stall,
  input  logic                          arvalid,
  output logic                          arready,
  input  logic [ingest_pkg::ADDR_W-1:0] araddr,
  input  logic [ingest_pkg::LEN8_W-1:0] arlen,
  output logic                          rvalid,
  input  logic                          rready,
  output logic [ingest_pkg::DATA_W-1:0] rdata,
  output logic                          rlast
);
  import ingest_pkg::*;

  logic              busy;
  logic [ADDR_W-1:0] beat_addr;
  logic [LEN8_W:0]   beats_left;
  logic              busy_q;
  logic [ADDR_W-1:0] addr_q;
  logic              last_q;

  // One burst at a time, handshakes taken on the rising edge
  always @(posedge data_clk) begin
    if (!data_rst_n) begin
      busy <= 1'b0;
    end else if (arvalid && arready) begin
      busy       <= 1'b1;
      beat_addr  <= araddr;
      beats_left <= {1'b0, arlen} + 9'd1;
    end else if (rvalid && rready) begin
      beat_addr  <= beat_addr + ADDR_W'(LINE_BYTES);
      beats_left <= beats_left - 9'd1;
      busy       <= (beats_left != 9'd1);
    end
  end

  // Response state shows up on the falling edge
  always @(negedge data_clk) begin
    busy_q <= busy;
    addr_q <= beat_addr;
    last_q <= (beats_left == 9'd1);
  end

  assign arready = !busy_q && !ar_stall;
  assign rvalid  = busy_q && !r_stall;
  // Upper half is the address, lower half its inverse
  assign rdata   = {addr_q[31:0], ~addr_q[31:0]};
  assign rlast   = last_q;

endmodule

// ==== input_channel.sv ====
`timescale 1ns/1ps

module input_channel (
  input  logic                          data_clk,
  input  logic                          data_rst_n,
  input  logic                          ctrl_start,
  output logic                          ctrl_done,
  input  logic [ingest_pkg::HASH_W-1:0] nfa_hash,
  input  logic [ingest_pkg::ADDR_W-1:0] nfadata_ptr,
  input  logic [ingest_pkg::LEN_W-1:0]  nfadata_cls,
  input  logic [ingest_pkg::ADDR_W-1:0] queries_ptr,
  input  logic [ingest_pkg::LEN_W-1:0]  queries_cls,
  // Memory read port
  output logic                          m_axi_arvalid,
  input  logic                          m_axi_arready,
  output logic [ingest_pkg::ADDR_W-1:0] m_axi_araddr,
  output logic [ingest_pkg::LEN8_W-1:0] m_axi_arlen,
  input  logic                          m_axi_rvalid,
  output logic                          m_axi_rready,
  input  logic [ingest_pkg::DATA_W-1:0] m_axi_rdata,
  input  logic                          m_axi_rlast,
  // Line stream toward the engine
  output logic                          m_axis_tvalid,
  input  logic                          m_axis_tready,
  output logic [ingest_pkg::DATA_W-1:0] m_axis_tdata,
  output logic                          m_axis_tlast,
  output ingest_pkg::line_type_e        m_axis_ttype
);

  logic nfa_start;
  logic query_start;

  axi_rd_if      nfa_mem ();
  axi_rd_if      query_mem ();
  axi_rd_if      mem ();
  line_stream_if nfa_lines ();
  line_stream_if query_lines ();
  line_stream_if out ();

  assign m_axi_arvalid = mem.arvalid;
  assign m_axi_araddr  = mem.araddr;
  assign m_axi_arlen   = mem.arlen;
  assign m_axi_rready  = mem.rready;
  assign mem.arready   = m_axi_arready;
  assign mem.rvalid    = m_axi_rvalid;
  assign mem.rdata     = m_axi_rdata;
  assign mem.rlast     = m_axi_rlast;

  assign m_axis_tvalid = out.tvalid;
  assign m_axis_tdata  = out.tdata;
  assign m_axis_tlast  = out.tlast;
  assign out.tready    = m_axis_tready;

  ingest_ctrl ctrl (
    .data_clk(data_clk), .data_rst_n(data_rst_n),
    .ctrl_start(ctrl_start), .nfa_hash(nfa_hash),
    .nfa_start(nfa_start), .query_start(query_start),
    .nfa_mem(nfa_mem), .query_mem(query_mem), .mem(mem),
    .nfa_lines(nfa_lines), .query_lines(query_lines), .out(out),
    .ttype(m_axis_ttype), .ctrl_done(ctrl_done)
  );

  read_channel nfa_channel (
    .data_clk(data_clk), .data_rst_n(data_rst_n),
    .start(nfa_start), .base_addr(nfadata_ptr), .line_count(nfadata_cls),
    .mem(nfa_mem), .lines(nfa_lines)
  );

  read_channel query_channel (
    .data_clk(data_clk), .data_rst_n(data_rst_n),
    .start(query_start), .base_addr(queries_ptr), .line_count(queries_cls),
    .mem(query_mem), .lines(query_lines)
  );

endmodule

// ==== ingest_ctrl.sv ====
`timescale 1ns/1ps

module ingest_ctrl (
  input  logic                          data_clk,
  input  logic                          data_rst_n,
  input  logic                          ctrl_start,
  input  logic [ingest_pkg::HASH_W-1:0] nfa_hash,
  output logic                          nfa_start,
  output logic                          query_start,
  axi_rd_if.slave                       nfa_mem,
  axi_rd_if.slave                       query_mem,
  axi_rd_if.master                      mem,
  line_stream_if.sink                   nfa_lines,
  line_stream_if.sink                   query_lines,
  line_stream_if.source                 out,
  output ingest_pkg::line_type_e        ttype,
  output logic                          ctrl_done
);
  import ingest_pkg::*;

  ingest_state_e     state;
  ingest_state_e     state_nxt;
  logic [HASH_W-1:0] hash_q;
  logic              accept;
  logic              reload;
  logic              nfa_sel;
  logic              query_sel;
  logic              nfa_done;

  ////////////////////////////////////////////////////////////////////////////
  // Phase sequencing
  ////////////////////////////////////////////////////////////////////////////

  assign accept    = (state == IDLE) && ctrl_start;
  // Same automaton as last run, skip the reload
  assign reload    = (nfa_hash != hash_q);
  assign nfa_sel   = (state == READ_NFA);
  assign query_sel = (state == READ_QUERY);
  assign nfa_done  = nfa_sel && nfa_lines.tvalid && out.tready && nfa_lines.tlast;
  assign ctrl_done = query_sel && query_lines.tvalid && out.tready && query_lines.tlast;

  always_comb begin
    case (state)
      IDLE:           state_nxt = !ctrl_start ? IDLE : (reload ? READ_NFA : WAIT_ALL_EDGES);
      READ_NFA:       state_nxt = nfa_done ? WAIT_ALL_EDGES : READ_NFA;
      WAIT_ALL_EDGES: state_nxt = READ_QUERY;
      READ_QUERY:     state_nxt = ctrl_done ? IDLE : READ_QUERY;
      default:        state_nxt = IDLE;
    endcase
  end

  // Channel starts fire in the first cycle of their phase
  always_ff @(posedge data_clk) begin
    if (!data_rst_n) begin
      state       <= IDLE;
      hash_q      <= '0;
      nfa_start   <= 1'b0;
      query_start <= 1'b0;
    end else begin
      state       <= state_nxt;
      nfa_start   <= accept && reload;
      query_start <= (state == WAIT_ALL_EDGES);
      if (accept) begin
        hash_q <= nfa_hash;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory port and stream sharing
  ////////////////////////////////////////////////////////////////////////////

  assign mem.arvalid = (nfa_sel && nfa_mem.arvalid) || (query_sel && query_mem.arvalid);
  assign mem.araddr  = nfa_sel ? nfa_mem.araddr : query_mem.araddr;
  assign mem.arlen   = nfa_sel ? nfa_mem.arlen : query_mem.arlen;
  assign mem.rready  = (nfa_sel && nfa_mem.rready) || (query_sel && query_mem.rready);

  assign nfa_mem.arready   = nfa_sel && mem.arready;
  assign nfa_mem.rvalid    = nfa_sel && mem.rvalid;
  assign nfa_mem.rdata     = mem.rdata;
  assign nfa_mem.rlast     = mem.rlast;
  assign query_mem.arready = query_sel && mem.arready;
  assign query_mem.rvalid  = query_sel && mem.rvalid;
  assign query_mem.rdata   = mem.rdata;
  assign query_mem.rlast   = mem.rlast;

  // Idle channel sees no tready
  assign out.tvalid = (nfa_sel && nfa_lines.tvalid) || (query_sel && query_lines.tvalid);
  assign out.tdata  = nfa_sel ? nfa_lines.tdata : query_lines.tdata;
  assign out.tlast  = (nfa_sel && nfa_lines.tlast) || (query_sel && query_lines.tlast);
  assign ttype      = query_sel ? QUERY_LINE : NFA_LINE;

  assign nfa_lines.tready   = nfa_sel && out.tready;
  assign query_lines.tready = query_sel && out.tready;

endmodule

// ==== read_channel.sv ====
`timescale 1ns/1ps

module read_channel (
  input  logic                          data_clk,
  input  logic                          data_rst_n,
  input  logic                          start,
  input  logic [ingest_pkg::ADDR_W-1:0] base_addr,
  input  logic [ingest_pkg::LEN_W-1:0]  line_count,
  axi_rd_if.master                      mem,
  line_stream_if.source                 lines
);
  import ingest_pkg::*;

  logic              wr_en;
  logic [DATA_W-1:0] wr_data;
  logic              room;
  logic              rd_valid;
  logic [DATA_W-1:0] rd_data;
  logic [LEN_W-1:0]  line_total;
  logic [LEN_W-1:0]  line_idx;
  logic              line_moves;

  burst_reader reader (
    .data_clk(data_clk), .data_rst_n(data_rst_n),
    .start(start), .base_addr(base_addr), .line_count(line_count),
    .room(room), .mem(mem),
    .wr_en(wr_en), .wr_data(wr_data)
  );

  line_fifo #(.DEPTH(FIFO_DEPTH)) buffer (
    .data_clk(data_clk), .data_rst_n(data_rst_n),
    .wr_en(wr_en), .wr_data(wr_data), .room(room),
    .rd_valid(rd_valid), .rd_data(rd_data), .rd_en(lines.tready)
  );

  assign lines.tvalid = rd_valid;
  assign lines.tdata  = rd_data;
  assign lines.tlast  = (line_idx == line_total - 1'b1);
  assign line_moves   = rd_valid && lines.tready;

  // Delivered line index, wraps on the last line of the phase
  always_ff @(posedge data_clk) begin
    if (!data_rst_n) begin
      line_total <= '0;
      line_idx   <= '0;
    end else if (start) begin
      line_total <= line_count;
      line_idx   <= '0;
    end else if (line_moves) begin
      line_idx <= lines.tlast ? '0 : line_idx + 1'b1;
    end
  end

endmodule

// ==== line_fifo.sv ====
`timescale 1ns/1ps

module line_fifo #(
  parameter int DEPTH = ingest_pkg::FIFO_DEPTH
) (
  input  logic                          data_clk,
  input  logic                          data_rst_n,
  input  logic                          wr_en,
  input  logic [ingest_pkg::DATA_W-1:0] wr_data,
  output logic                          room,
  output logic                          rd_valid,
  output logic [ingest_pkg::DATA_W-1:0] rd_data,
  input  logic                          rd_en
);
  import ingest_pkg::*;

  logic [DATA_W-1:0]          line_mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       pop;

  // Head entry is shown directly
  assign rd_valid = (count != '0);
  assign rd_data  = line_mem[rd_ptr];
  assign pop      = rd_en && rd_valid;

  // Room for a whole burst, counting a write landing this cycle
  assign room = (int'(count) + int'(wr_en)) <= (DEPTH - LINE_BURST);

  always_ff @(posedge data_clk) begin
    if (wr_en) begin
      line_mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge data_clk) begin
    if (!data_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== burst_reader.sv ====
`timescale 1ns/1ps

module burst_reader (
  input  logic                          data_clk,
  input  logic                          data_rst_n,
  input  logic                          start,
  input  logic [ingest_pkg::ADDR_W-1:0] base_addr,
  input  logic [ingest_pkg::LEN_W-1:0]  line_count,
  input  logic                          room,
  axi_rd_if.master                      mem,
  output logic                          wr_en,
  output logic [ingest_pkg::DATA_W-1:0] wr_data
);
  import ingest_pkg::*;

  logic [ADDR_W-1:0] next_addr;
  logic [LEN_W-1:0]  lines_left;
  logic [LEN_W-1:0]  burst_lines;
  logic              ar_pending;
  logic              in_burst;
  logic              ar_done;
  logic              last_beat;
  logic              issue;

  ////////////////////////////////////////////////////////////////////////////
  // Burst sizing
  ////////////////////////////////////////////////////////////////////////////

  // Full bursts first, the remainder at the end
  assign burst_lines = (lines_left < LEN_W'(LINE_BURST)) ? lines_left : LEN_W'(LINE_BURST);

  assign ar_done   = ar_pending && mem.arready;
  assign last_beat = wr_en && mem.rlast;

  // Next request may go out in the cycle of the previous rlast beat
  assign issue = !ar_pending && (!in_burst || last_beat) && (lines_left != '0) && room;

  ////////////////////////////////////////////////////////////////////////////
  // Request sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge data_clk) begin
    if (!data_rst_n) begin
      ar_pending <= 1'b0;
      in_burst   <= 1'b0;
      lines_left <= '0;
    end else if (start) begin
      ar_pending <= room && (line_count != '0);
      in_burst   <= 1'b0;
      lines_left <= line_count;
    end else begin
      if (last_beat) begin
        in_burst <= 1'b0;
      end
      if (ar_done) begin
        ar_pending <= 1'b0;
        in_burst   <= 1'b1;
        lines_left <= lines_left - burst_lines;
      end else if (issue) begin
        ar_pending <= 1'b1;
      end
    end
  end

  // Address only moves on acceptance, so it holds while arvalid is up
  always_ff @(posedge data_clk) begin
    if (start) begin
      next_addr <= base_addr;
    end else if (ar_done) begin
      next_addr <= next_addr + ADDR_W'(burst_lines) * ADDR_W'(LINE_BYTES);
    end
  end

  assign mem.arvalid = ar_pending;
  assign mem.araddr  = next_addr;
  assign mem.arlen   = LEN8_W'(burst_lines - 1'b1);
  // Buffer room was reserved before the request
  assign mem.rready  = in_burst;

  assign wr_en   = mem.rvalid && mem.rready;
  assign wr_data = mem.rdata;

endmodule

// ==== line_stream_if.sv ====
`timescale 1ns/1ps

interface line_stream_if;
  import ingest_pkg::*;

  logic              tvalid;
  logic              tready;
  logic [DATA_W-1:0] tdata;
  // Last line of the current phase
  logic              tlast;

  modport source (
    output tvalid, tdata, tlast,
    input  tready
  );

  modport sink (
    input  tvalid, tdata, tlast,
    output tready
  );

endinterface

// ==== axi_rd_if.sv ====
`timescale 1ns/1ps

interface axi_rd_if;
  import ingest_pkg::*;

  // Read address channel
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;
  logic [LEN8_W-1:0] arlen;

  // Read data channel
  logic              rvalid;
  logic              rready;
  logic [DATA_W-1:0] rdata;
  logic              rlast;

  modport master (
    output arvalid, araddr, arlen, rready,
    input  arready, rvalid, rdata, rlast
  );

  modport slave (
    input  arvalid, araddr, arlen, rready,
    output arready, rvalid, rdata, rlast
  );

endinterface

// ==== ingest_pkg.sv ====
package ingest_pkg;

  // Memory and line geometry
  localparam int ADDR_W     = 64;
  localparam int DATA_W     = 64;
  localparam int LINE_BYTES = DATA_W / 8;

  // Line counts and burst shape
  localparam int LEN_W      = 32;
  localparam int LINE_BURST = 16;
  localparam int LEN8_W     = 8;

  // Two full bursts of buffering per channel
  localparam int FIFO_DEPTH = 32;

  localparam int HASH_W     = 64;

  // Phases of one run
  typedef enum logic [1:0] {
    IDLE           = 2'd0,
    READ_NFA       = 2'd1,
    WAIT_ALL_EDGES = 2'd2,
    READ_QUERY     = 2'd3
  } ingest_state_e;

  // Kind of line on the output stream
  typedef enum logic {
    NFA_LINE   = 1'b0,
    QUERY_LINE = 1'b1
  } line_type_e;

endpackage
